//--- hw/conv2_pkg.sv
/* shared sizes, address steps and data types for the second convolution stage
   every RTL file and the testbench refer to these through conv2_pkg:: names */
package conv2_pkg;

    // feature map written by the first pooling layer
    localparam int fmap_width  = 12;
    localparam int fmap_height = 12;
    localparam int fmap_words  = fmap_width * fmap_height;

    // one square kernel, no padding, stride one
    localparam int kernel_size = 5;
    localparam int tap_count   = kernel_size * kernel_size;

    // output map is 8 by 8, split into two halves of 4 rows each
    localparam int out_width   = fmap_width - kernel_size + 1;
    localparam int lane_rows   = 4;
    localparam int lane_pixels = lane_rows * out_width;

    // lane 1 starts reading at row 4 of the feature map
    localparam int half_offset = lane_rows * fmap_width;

    // address moves of the window walk
    // next tap in the same kernel row
    localparam int step_tap   = 1;
    // down one row and back to the first kernel column
    localparam int step_krow  = fmap_width - kernel_size + 1;
    // up four rows, back four columns, then one pixel right
    localparam int step_pixel = -((kernel_size - 1) * fmap_width + kernel_size - 2);
    // up four rows, back to column 0, then down one row
    localparam int step_row   = -((kernel_size - 1) * fmap_width + fmap_width - 1 - fmap_width);

    // feature-map pixels are unsigned, kernel weights are signed
    typedef logic [7:0] pixel_t;
    typedef logic signed [7:0] weight_t;

    // 25 products of 255 and -128 need 21 bits with sign
    typedef logic signed [20:0] acc_t;

    // 144 words fit in an 8-bit address
    typedef logic [7:0] fmap_addr_t;

    // tap index 0 to 24, row times 5 plus column
    typedef logic [4:0] tap_t;

    // output pixel index, row times 8 plus column
    typedef logic [5:0] out_index_t;

endpackage

//--- hw/fmap_ram.sv
/* single-port feature-map memory, 144 pixels, shared by the host and both lanes
   writes land at the clock edge, read data is registered one cycle after the address */
module fmap_ram (
    input  logic                  clk,
    input  logic                  we,
    input  conv2_pkg::fmap_addr_t addr,
    input  conv2_pkg::pixel_t     wdata,
    output conv2_pkg::pixel_t     rdata
);

    // pixel storage, row-major with 12 pixels per row
    conv2_pkg::pixel_t mem [conv2_pkg::fmap_words];

    // the host owns the port while it writes
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read every cycle, the arbiter only steers a lane address here when it grants
    // a read during a write returns the old word, which nobody uses
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

//--- hw/kernel_store.sv
/* holds the 25 signed kernel weights loaded by the host
   each lane reads through its own port so kernel reads never wait */
module kernel_store (
    input  logic               clk,
    input  logic               we,
    input  conv2_pkg::tap_t    waddr,
    input  conv2_pkg::weight_t wdata,
    input  conv2_pkg::tap_t    tap0,
    input  conv2_pkg::tap_t    tap1,
    output conv2_pkg::weight_t weight0,
    output conv2_pkg::weight_t weight1
);

    // one weight per tap, index is kernel row times 5 plus kernel column
    conv2_pkg::weight_t weights [conv2_pkg::tap_count];

    // the host only writes before a run starts
    always_ff @(posedge clk) begin
        if (we) begin
            weights[waddr] <= wdata;
        end
    end

    // combinational reads, the lane registers the weight together with its grant
    always_comb begin
        weight0 = weights[tap0];
        weight1 = weights[tap1];
    end

endmodule

//--- hw/fmap_arbiter.sv
/* places the host writer and the two convolution lanes on the feature-map memory
   host writes win outright, the lanes share the port round-robin */
module fmap_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  host_we,
    input  conv2_pkg::fmap_addr_t host_addr,
    input  logic                  req0,
    input  logic                  req1,
    input  conv2_pkg::fmap_addr_t addr0,
    input  conv2_pkg::fmap_addr_t addr1,
    output logic                  grant0,
    output logic                  grant1,
    output logic                  mem_we,
    output conv2_pkg::fmap_addr_t mem_addr
);

    // lane that goes first when both request, 0 or 1
    logic prefer1;
    // lanes may only use the port when the host is not writing
    logic lanes_free;

    assign lanes_free = !host_we;

    // a lone requester always wins, a tie goes to the lane served less recently
    always_comb begin
        grant0 = lanes_free && req0 && (!req1 || !prefer1);
        grant1 = lanes_free && req1 && (!req0 || prefer1);
    end

    // the host write strobe goes straight through
    assign mem_we = host_we;

    // steer the address of whoever owns the port this cycle
    always_comb begin
        if (host_we) begin
            mem_addr = host_addr;
        end else if (grant1) begin
            mem_addr = addr1;
        end else begin
            mem_addr = addr0;
        end
    end

    // the pointer moves to the other lane after every lane grant
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prefer1 <= 1'b0;
        end else if (grant0) begin
            prefer1 <= 1'b1;
        end else if (grant1) begin
            prefer1 <= 1'b0;
        end
    end

endmodule

//--- hw/window_addr_gen.sv
/* walks the 5 by 5 window over one lane's four output rows
   step advances by one tap, start reloads the lane's base address */
module window_addr_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  step,
    input  conv2_pkg::fmap_addr_t base,
    output conv2_pkg::fmap_addr_t addr,
    output conv2_pkg::tap_t       tap,
    output logic                  pixel_done,
    output logic                  last
);

    localparam logic [2:0] kernel_last = 3'(conv2_pkg::kernel_size - 1);
    localparam logic [2:0] pos_last    = 3'(conv2_pkg::out_width - 1);
    localparam logic [1:0] row_last    = 2'(conv2_pkg::lane_rows - 1);

    // kernel row and column inside the current window
    logic [2:0] krow;
    logic [2:0] kcol;
    // output column within the current output row
    logic [2:0] pos;
    // output row within this lane's half
    logic [1:0] orow;

    // the 25th tap of a window is its bottom right corner
    assign pixel_done = (krow == kernel_last) && (kcol == kernel_last);
    // final tap of the final pixel of the half
    assign last = pixel_done && (pos == pos_last) && (orow == row_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // base is a constant tied off by the lane
            addr <= base;
            tap  <= '0;
            krow <= '0;
            kcol <= '0;
            pos  <= '0;
            orow <= '0;
        end else if (start || (step && last)) begin
            // a finished walk parks at the base again, ready for the next run
            addr <= base;
            tap  <= '0;
            krow <= '0;
            kcol <= '0;
            pos  <= '0;
            orow <= '0;
        end else if (step) begin
            if (pixel_done && pos == pos_last) begin
                // end of an output row, back to column 0 one row lower
                addr <= addr + conv2_pkg::fmap_addr_t'(conv2_pkg::step_row);
                tap  <= '0;
                krow <= '0;
                kcol <= '0;
                pos  <= '0;
                orow <= orow + 2'd1;
            end else if (pixel_done) begin
                // window done, slide one pixel to the right
                addr <= addr + conv2_pkg::fmap_addr_t'(conv2_pkg::step_pixel);
                tap  <= '0;
                krow <= '0;
                kcol <= '0;
                pos  <= pos + 3'd1;
            end else if (kcol == kernel_last) begin
                // end of a kernel row, down one feature-map row
                addr <= addr + conv2_pkg::fmap_addr_t'(conv2_pkg::step_krow);
                tap  <= tap + 5'd1;
                krow <= krow + 3'd1;
                kcol <= '0;
            end else begin
                addr <= addr + conv2_pkg::fmap_addr_t'(conv2_pkg::step_tap);
                tap  <= tap + 5'd1;
                kcol <= kcol + 3'd1;
            end
        end
    end

endmodule

//--- hw/conv_lane.sv
/* one convolution lane covering four output rows of the 8 by 8 map
   it issues 800 tap reads, accumulates pixel times weight and strobes each sum out */
module conv_lane #(
    // 0 for output rows 0 to 3, 1 for output rows 4 to 7
    parameter bit lane = 1'b0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  grant,
    input  conv2_pkg::pixel_t     rdata,
    input  conv2_pkg::weight_t    weight,
    output logic                  req,
    output conv2_pkg::fmap_addr_t addr,
    output conv2_pkg::tap_t       tap,
    output logic                  result_valid,
    output conv2_pkg::acc_t       result,
    output conv2_pkg::out_index_t result_index,
    output logic                  finished
);

    // first feature-map word and first output index of this lane's half
    localparam conv2_pkg::fmap_addr_t base =
        lane ? conv2_pkg::fmap_addr_t'(conv2_pkg::half_offset) : '0;
    localparam conv2_pkg::out_index_t index_base =
        lane ? conv2_pkg::out_index_t'(conv2_pkg::lane_pixels) : '0;

    logic pixel_done;
    logic last;

    // issue side, high while taps are left to read
    logic active;

    // accumulate stage, one tap behind the grant, lines up with the memory read data
    logic               s1_valid;
    logic               s1_pixel_done;
    logic               s1_last;
    conv2_pkg::weight_t s1_weight;

    logic signed [16:0]    product;
    conv2_pkg::acc_t       acc;
    conv2_pkg::acc_t       sum;
    conv2_pkg::out_index_t next_index;

    // the grant is the step, so the address and tap move in the cycle after it
    window_addr_gen u_addr_gen (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .step       (grant),
        .base       (base),
        .addr       (addr),
        .tap        (tap),
        .pixel_done (pixel_done),
        .last       (last)
    );

    assign req = active;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end else if (grant && last) begin
            // the final tap of the half has been issued
            active <= 1'b0;
        end
    end

    // flags of the granted tap travel with it into the accumulate stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid      <= 1'b0;
            s1_pixel_done <= 1'b0;
            s1_last       <= 1'b0;
        end else begin
            s1_valid      <= grant;
            s1_pixel_done <= grant && pixel_done;
            s1_last       <= grant && last;
        end
    end

    // weight of the granted tap, read combinationally from the kernel store
    always_ff @(posedge clk) begin
        if (grant) begin
            s1_weight <= weight;
        end
    end

    // pixel is unsigned, so widen it with a zero before the signed multiply
    assign product = $signed({1'b0, rdata}) * s1_weight;
    assign sum     = acc + conv2_pkg::acc_t'(product);

    // a finished pixel leaves the accumulator at zero for the next one
    // the next pixel's first tap can already be in the issue stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc          <= '0;
            result_valid <= 1'b0;
            finished     <= 1'b0;
            next_index   <= index_base;
        end else begin
            result_valid <= 1'b0;
            if (start) begin
                acc        <= '0;
                finished   <= 1'b0;
                next_index <= index_base;
            end else if (s1_valid && s1_pixel_done) begin
                acc          <= '0;
                result_valid <= 1'b1;
                next_index   <= next_index + 6'd1;
                // stays high after the last result until the next start
                if (s1_last) begin
                    finished <= 1'b1;
                end
            end else if (s1_valid) begin
                acc <= sum;
            end
        end
    end

    // result payload, only meaningful while result_valid is high
    always_ff @(posedge clk) begin
        if (s1_valid && s1_pixel_done) begin
            result       <= sum;
            result_index <= next_index;
        end
    end

endmodule

//--- hw/conv2_top.sv
/* second convolution stage, one 5 by 5 kernel over a 12 by 12 map, two lanes
   load the map and kernel through the host port, then pulse start and wait for done */
module conv2_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  load_fmap,
    input  logic                  load_kernel,
    input  conv2_pkg::fmap_addr_t load_addr,
    input  logic [7:0]            load_data,
    output logic                  busy,
    output logic                  done,
    output logic                  result0_valid,
    output conv2_pkg::acc_t       result0,
    output conv2_pkg::out_index_t result0_index,
    output logic                  result1_valid,
    output conv2_pkg::acc_t       result1,
    output conv2_pkg::out_index_t result1_index
);

    logic                  mem_we;
    conv2_pkg::fmap_addr_t mem_addr;
    conv2_pkg::pixel_t     mem_rdata;

    logic                  req0;
    logic                  req1;
    logic                  grant0;
    logic                  grant1;
    conv2_pkg::fmap_addr_t addr0;
    conv2_pkg::fmap_addr_t addr1;
    conv2_pkg::tap_t       tap0;
    conv2_pkg::tap_t       tap1;
    conv2_pkg::weight_t    weight0;
    conv2_pkg::weight_t    weight1;
    logic                  finished0;
    logic                  finished1;

    // both lanes have put out their last result
    logic                  all_finished;

    fmap_ram u_fmap_ram (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (conv2_pkg::pixel_t'(load_data)),
        .rdata (mem_rdata)
    );

    // kernel loads reuse the low bits of the host address as the tap index
    kernel_store u_kernel_store (
        .clk     (clk),
        .we      (load_kernel),
        .waddr   (conv2_pkg::tap_t'(load_addr)),
        .wdata   (conv2_pkg::weight_t'(load_data)),
        .tap0    (tap0),
        .tap1    (tap1),
        .weight0 (weight0),
        .weight1 (weight1)
    );

    fmap_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .host_we   (load_fmap),
        .host_addr (load_addr),
        .req0      (req0),
        .req1      (req1),
        .addr0     (addr0),
        .addr1     (addr1),
        .grant0    (grant0),
        .grant1    (grant1),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr)
    );

    // both lanes see the same read data, only the granted one takes it
    conv_lane #(.lane(1'b0)) u_lane0 (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .grant        (grant0),
        .rdata        (mem_rdata),
        .weight       (weight0),
        .req          (req0),
        .addr         (addr0),
        .tap          (tap0),
        .result_valid (result0_valid),
        .result       (result0),
        .result_index (result0_index),
        .finished     (finished0)
    );

    conv_lane #(.lane(1'b1)) u_lane1 (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .grant        (grant1),
        .rdata        (mem_rdata),
        .weight       (weight1),
        .req          (req1),
        .addr         (addr1),
        .tap          (tap1),
        .result_valid (result1_valid),
        .result       (result1),
        .result_index (result1_index),
        .finished     (finished1)
    );

    assign all_finished = finished0 && finished1;

    // the finished flags rise in the cycle of each lane's last result
    // they are still high from the previous run in the start cycle, busy masks that
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= busy && all_finished;
            if (start) begin
                busy <= 1'b1;
            end else if (all_finished) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- verification/conv2_tb.sv
/* testbench for the second convolution stage, loads random and extreme maps and kernels
   then runs both lanes and checks every result, its index and the done pulse against a model */
module conv2_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int out_pixels     = conv2_pkg::out_width * conv2_pkg::out_width;
    localparam int run_count      = 4;
    localparam int cycles_per_run = 4000;
    localparam logic [31:0] lfsr_seed = 32'hff2f;
    // feedback mask of x^32 + x^22 + x^2 + x + 1 for a right-shifting Galois LFSR
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic                  clk;
    logic                  reset;
    logic                  start;
    logic                  load_fmap;
    logic                  load_kernel;
    conv2_pkg::fmap_addr_t load_addr;
    logic [7:0]            load_data;
    logic                  busy;
    logic                  done;
    logic                  result0_valid;
    conv2_pkg::acc_t       result0;
    conv2_pkg::out_index_t result0_index;
    logic                  result1_valid;
    conv2_pkg::acc_t       result1;
    conv2_pkg::out_index_t result1_index;

    logic [31:0]        lfsr_state;
    // host-side copy of what gets loaded and of what the model reads
    conv2_pkg::pixel_t  pixels [conv2_pkg::fmap_words];
    conv2_pkg::weight_t weights [conv2_pkg::tap_count];
    conv2_pkg::acc_t    expected [out_pixels];
    // results seen per lane and done pulses seen in the current run
    int                 count0;
    int                 count1;
    int                 done_count;
    // high from start until the run has been checked, and strobes outside it are errors
    logic               run_open;
    string              test_name;

    conv2_top DUT (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .load_fmap     (load_fmap),
        .load_kernel   (load_kernel),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .busy          (busy),
        .done          (done),
        .result0_valid (result0_valid),
        .result0       (result0),
        .result0_index (result0_index),
        .result1_valid (result1_valid),
        .result1       (result1),
        .result1_index (result1_index)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one shift of the LFSR where the bit that falls out is state[0] before the shift
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end
        return state >> 1;
    endfunction

    // collects n bits msb first with one LFSR step per bit
    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // sum over the 5 by 5 window at output row r and column c with unsigned pixels
    function automatic conv2_pkg::acc_t model_output(int index);
        int row;
        int col;
        int total;
        row   = index / conv2_pkg::out_width;
        col   = index % conv2_pkg::out_width;
        total = 0;
        for (int kr = 0; kr < conv2_pkg::kernel_size; kr++) begin
            for (int kc = 0; kc < conv2_pkg::kernel_size; kc++) begin
                total += int'(pixels[(row + kr) * conv2_pkg::fmap_width + col + kc])
                    * int'(weights[kr * conv2_pkg::kernel_size + kc]);
            end
        end
        return conv2_pkg::acc_t'(total);
    endfunction

    task automatic stop_on_failure(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_acc(string name, conv2_pkg::acc_t exp, conv2_pkg::acc_t act);
        if (act !== exp) begin
            stop_on_failure($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_index(string name, conv2_pkg::out_index_t exp,
                               conv2_pkg::out_index_t act);
        if (act !== exp) begin
            stop_on_failure($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            stop_on_failure($sformatf("ERROR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // draws a new random map and kernel and takes the expected values from the model
    task automatic fill_random();
        logic [7:0] value;
        for (int i = 0; i < conv2_pkg::fmap_words; i++) begin
            take_bits(8, value);
            pixels[i] = conv2_pkg::pixel_t'(value);
        end
        for (int i = 0; i < conv2_pkg::tap_count; i++) begin
            take_bits(8, value);
            weights[i] = conv2_pkg::weight_t'(value);
        end
        for (int i = 0; i < out_pixels; i++) begin
            expected[i] = model_output(i);
        end
    endtask

    // flat map and kernel where every output is the same known sum
    task automatic fill_constant(conv2_pkg::pixel_t pixel, conv2_pkg::weight_t weight,
                                 conv2_pkg::acc_t result);
        for (int i = 0; i < conv2_pkg::fmap_words; i++) begin
            pixels[i] = pixel;
        end
        for (int i = 0; i < conv2_pkg::tap_count; i++) begin
            weights[i] = weight;
        end
        for (int i = 0; i < out_pixels; i++) begin
            expected[i] = result;
        end
    endtask

    // one host write per cycle that lands at the edge ending its strobe cycle
    task automatic load_memories();
        for (int i = 0; i < conv2_pkg::fmap_words; i++) begin
            @(posedge clk);
            #1;
            load_fmap = 1'b1;
            load_addr = conv2_pkg::fmap_addr_t'(i);
            load_data = pixels[i];
        end
        @(posedge clk);
        #1;
        load_fmap = 1'b0;
        for (int i = 0; i < conv2_pkg::tap_count; i++) begin
            @(posedge clk);
            #1;
            load_kernel = 1'b1;
            load_addr   = conv2_pkg::fmap_addr_t'(i);
            load_data   = 8'(weights[i]);
        end
        @(posedge clk);
        #1;
        load_kernel = 1'b0;
    endtask

    task automatic run_layer(string name);
        test_name  = name;
        count0     = 0;
        count1     = 0;
        done_count = 0;
        @(posedge clk);
        #1;
        start    = 1'b1;
        run_open = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        // the watchdog catches a done that never comes
        while (done_count == 0) begin
            @(posedge clk);
        end
        // a stray second done would show up within these cycles
        repeat (20) @(posedge clk);
        check_bit({name, " exactly one done"}, 1'b1, done_count == 1);
        check_bit({name, " busy after done"}, 1'b0, busy);
        run_open = 1'b0;
    endtask

    // results have no back-pressure so every strobe is taken mid-cycle in its own cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (!run_open) begin
                check_bit({test_name, " busy while idle"}, 1'b0, busy);
                check_bit({test_name, " done while idle"}, 1'b0, done);
                check_bit({test_name, " result0_valid while idle"}, 1'b0, result0_valid);
                check_bit({test_name, " result1_valid while idle"}, 1'b0, result1_valid);
            end
            if (result0_valid) begin
                // busy covers every cycle up to and including the last result
                check_bit({test_name, " busy with lane 0 result"}, 1'b1, busy);
                // lane 0 owns indices 0 to 31 in row-major order
                check_index({test_name, " lane 0 index"}, conv2_pkg::out_index_t'(count0),
                            result0_index);
                check_acc({test_name, " lane 0 result"}, expected[count0], result0);
                count0++;
            end
            if (result1_valid) begin
                check_bit({test_name, " busy with lane 1 result"}, 1'b1, busy);
                check_index({test_name, " lane 1 index"},
                            conv2_pkg::out_index_t'(conv2_pkg::lane_pixels + count1),
                            result1_index);
                check_acc({test_name, " lane 1 result"},
                          expected[conv2_pkg::lane_pixels + count1], result1);
                count1++;
            end
            if (done) begin
                done_count++;
                check_bit({test_name, " busy low with done"}, 1'b0, busy);
                check_bit({test_name, " lane 0 complete at done"}, 1'b1,
                          count0 == conv2_pkg::lane_pixels);
                check_bit({test_name, " lane 1 complete at done"}, 1'b1,
                          count1 == conv2_pkg::lane_pixels);
            end
        end
    end

    // one run takes about 1600 cycles and each load adds under 200
    initial begin
        repeat (run_count * cycles_per_run) @(posedge clk);
        stop_on_failure($sformatf("watchdog expired after %0d cycles, the runs did not finish",
                                  run_count * cycles_per_run));
    end

    initial begin
        lfsr_state  = lfsr_seed;
        reset       = 1'b1;
        start       = 1'b0;
        load_fmap   = 1'b0;
        load_kernel = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        run_open    = 1'b0;
        count0      = 0;
        count1      = 0;
        done_count  = 0;
        test_name   = "idle after reset";
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // the monitor checks that everything stays quiet before the first start
        repeat (10) @(posedge clk);
        fill_random();
        load_memories();
        run_layer("random run 1");
        // largest negative and positive sums the accumulator must hold
        fill_constant(8'd255, -8'sd128, conv2_pkg::acc_t'(-816000));
        load_memories();
        run_layer("pixels 255 weights -128");
        fill_constant(8'd255, 8'sd127, conv2_pkg::acc_t'(809625));
        load_memories();
        run_layer("pixels 255 weights 127");
        // fresh data after three runs exercises the restart of the walk and the pointer
        fill_random();
        load_memories();
        run_layer("random run 2");
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- compile.f
hw/conv2_pkg.sv
hw/fmap_ram.sv
hw/kernel_store.sv
hw/fmap_arbiter.sv
hw/window_addr_gen.sv
hw/conv_lane.sv
hw/conv2_top.sv
verification/conv2_tb.sv

//--- Makefile
# Verilator build and run for the second convolution stage
# every variable can be overridden on the command line, e.g. make BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= conv2_tb
RTL_TOP    ?= conv2_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
PASS_TEXT  ?= Simulation passed
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard hw/*.sv verification/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
